// ==== rtl/cam_bist_pkg.sv ====
// Shared sizes, constants and bus types for the CAM BIST engine.
// The CAM is fixed at 16 entries of 16 bits; addr_width must match cam_entries.
// Write data is the background field on top of the entry address, so every
// entry holds a unique word as long as addr_width covers all entries.
`default_nettype none

package cam_bist_pkg;

   // ------------------------------------------------------------------------
   // Array geometry
   // ------------------------------------------------------------------------
   localparam int cam_width   = 16;
   localparam int cam_entries = 16;
   localparam int addr_width  = 4;

   // Upper part of each word, above the address field
   localparam int bg_width = cam_width - addr_width;

   // Background pattern, alternating nibbles to toggle neighbouring cells
   localparam logic [bg_width-1:0] bist_background = 12'hA5C;

   // ------------------------------------------------------------------------
   // Engine phases
   // ------------------------------------------------------------------------
   typedef enum logic [2:0] {
      phase_idle    = 3'd0,
      phase_write   = 3'd1,
      phase_compare = 3'd2,
      phase_drain   = 3'd3,
      phase_done    = 3'd4
   } bist_phase_t;

   // ------------------------------------------------------------------------
   // CAM port bundles
   // ------------------------------------------------------------------------
   // Write port, one entry per cycle
   typedef struct packed {
      logic                  wr_en;
      logic [addr_width-1:0] addr;
      logic [cam_width-1:0]  data;
   } cam_wr_t;

   // Compare port, key is also the functional search key
   typedef struct packed {
      logic                 valid;
      logic [cam_width-1:0] key;
   } cam_cmp_t;

   // Match result, registered inside the CAM
   typedef struct packed {
      logic                  hit;
      logic [addr_width-1:0] addr;
   } cam_match_t;

   // Run configuration, held stable for a whole run
   typedef struct packed {
      logic data_inv;
      logic cd_mask_en;
   } bist_cfg_t;

   // Status seen by the test controller
   typedef struct packed {
      logic                  busy;
      logic                  done;
      logic                  fail;
      logic [addr_width-1:0] fail_addr;
   } bist_status_t;

endpackage

`default_nettype wire

// ==== rtl/cam_bist_ctrl.sv ====
// Phase sequencer for the CAM BIST run.
// A start pulse is only taken in idle; it is ignored while a run is busy.
// Phase changes follow the counter wrap flag, so write and compare length
// are set by the address counter, not here.
`timescale 1ns/1ps
`default_nettype none

module cam_bist_ctrl (
   input  wire logic                      bist_clk,
   input  wire logic                      rst_b,
   input  wire logic                      start,
   input  wire logic                      cnt_wrap,
   output cam_bist_pkg::bist_phase_t      phase,
   output logic                           cnt_en,
   output logic                           cnt_clr,
   output logic                           status_busy,
   output logic                           status_done
);

   cam_bist_pkg::bist_phase_t phase_nxt;

   // ------------------------------------------------------------------------
   // Next phase
   // ------------------------------------------------------------------------
   always_comb begin
      phase_nxt = phase;
      case (phase)
         cam_bist_pkg::phase_idle: begin
            if (start) begin
               phase_nxt = cam_bist_pkg::phase_write;
            end
         end
         cam_bist_pkg::phase_write: begin
            // Last entry written
            if (cnt_wrap) begin
               phase_nxt = cam_bist_pkg::phase_compare;
            end
         end
         cam_bist_pkg::phase_compare: begin
            // Masked compare of last entry issued
            if (cnt_wrap) begin
               phase_nxt = cam_bist_pkg::phase_drain;
            end
         end
         // One cycle for the final match result to return
         cam_bist_pkg::phase_drain: phase_nxt = cam_bist_pkg::phase_done;
         cam_bist_pkg::phase_done:  phase_nxt = cam_bist_pkg::phase_idle;
         default:                   phase_nxt = cam_bist_pkg::phase_idle;
      endcase
   end

   // Phase register
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         phase <= cam_bist_pkg::phase_idle;
      end else begin
         phase <= phase_nxt;
      end
   end

   // ------------------------------------------------------------------------
   // Counter control and status
   // ------------------------------------------------------------------------
   // Clear on an accepted start so the write phase begins at entry 0
   assign cnt_clr = (phase == cam_bist_pkg::phase_idle) && start;

   // Step only while stimulus is being issued
   assign cnt_en = (phase == cam_bist_pkg::phase_write) ||
                   (phase == cam_bist_pkg::phase_compare);

   // Busy covers write through drain
   assign status_busy = (phase == cam_bist_pkg::phase_write)   ||
                        (phase == cam_bist_pkg::phase_compare) ||
                        (phase == cam_bist_pkg::phase_drain);

   assign status_done = (phase == cam_bist_pkg::phase_done);

   // Done lasts one cycle and the next phase is idle rather than busy
   a_done_not_busy : assert property (
      @(posedge bist_clk) disable iff (!rst_b)
         status_done |=> !status_done && !status_busy
   );

endmodule

`default_nettype wire

// ==== rtl/cam_bist_addr_cnt.sv ====
// Entry counter for the BIST engine.
// Write phase walks the address alone; compare phase walks {addr, step},
// so each entry gets a plain then a masked compare. Wrap is combinational.
`timescale 1ns/1ps
`default_nettype none

module cam_bist_addr_cnt (
   input  wire logic                                    bist_clk,
   input  wire logic                                    rst_b,
   input  wire logic                                    cnt_en,
   input  wire logic                                    cnt_clr,
   input  wire cam_bist_pkg::bist_phase_t               phase,
   output logic [cam_bist_pkg::addr_width-1:0]          addr,
   output logic                                         step,
   output logic                                         cnt_wrap
);

   logic in_compare;
   logic last_addr;

   assign in_compare = (phase == cam_bist_pkg::phase_compare);
   assign last_addr  = (addr == cam_bist_pkg::addr_width'(cam_bist_pkg::cam_entries - 1));

   // Step bit sits below the address, so address moves after the masked step
   always_ff @(posedge bist_clk) begin
      if (!rst_b || cnt_clr) begin
         addr <= '0;
         step <= 1'b0;
      end else if (cnt_en) begin
         if (in_compare) begin
            {addr, step} <= {addr, step} + 1'b1;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   // Last count of the phase: last entry, and its masked step in compare
   assign cnt_wrap = cnt_en && last_addr && (!in_compare || step);

   // Step bit only toggles in the compare phase
   a_step_in_compare : assert property (
      @(posedge bist_clk) disable iff (!rst_b) !in_compare |-> !step
   );

endmodule

`default_nettype wire

// ==== rtl/cam_bist_inhandler.sv ====
// CAM input handler for the BIST engine.
// Builds write data and compare keys from the background and entry address.
// Mask rotation has priority over a scan load; a scan load may leave the
// mask with any pattern, the engine still rotates whatever was loaded.
// Outside the compare phase the CAM key is the functional key.
`timescale 1ns/1ps
`default_nettype none

module cam_bist_inhandler (
   input  wire logic                                   bist_clk,
   input  wire logic                                   rst_b,
   input  wire cam_bist_pkg::bist_phase_t              phase,
   input  wire logic [cam_bist_pkg::addr_width-1:0]    addr,
   input  wire logic                                   step,
   input  wire cam_bist_pkg::bist_cfg_t                cfg,
   input  wire logic                                   fscan_mode,
   input  wire logic [cam_bist_pkg::cam_width-1:0]     func_key,
   output cam_bist_pkg::cam_wr_t                       cam_wr,
   output cam_bist_pkg::cam_cmp_t                      cam_cmp
);

   logic [cam_bist_pkg::cam_width-1:0] bist_mask;
   logic [cam_bist_pkg::cam_width-1:0] wr_data;
   logic [cam_bist_pkg::cam_width-1:0] cmp_data;
   logic                               in_compare;
   logic                               rotate_mask;
   logic                               scan_loaded;

   assign in_compare = (phase == cam_bist_pkg::phase_compare);

   // Rotate at the end of every masked compare
   assign rotate_mask = in_compare && step;

   // ------------------------------------------------------------------------
   // Rotating mask
   // ------------------------------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bist_mask <= cam_bist_pkg::cam_width'(1);
      end else if (rotate_mask) begin
         // Rotate left, msb wraps into bit 0
         bist_mask <= {bist_mask[cam_bist_pkg::cam_width-2:0],
                       bist_mask[cam_bist_pkg::cam_width-1]};
      end else if (fscan_mode) begin
         // Scan load from the functional key
         bist_mask <= func_key;
      end
   end

   // Tracks whether the mask may have left its one-hot pattern
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         scan_loaded <= 1'b0;
      end else if (fscan_mode && !rotate_mask) begin
         scan_loaded <= 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // Write and compare data
   // ------------------------------------------------------------------------
   // Unique word per entry, whole word inverted for the inverse pattern
   assign wr_data = {cam_bist_pkg::bist_background, addr} ^
                    {cam_bist_pkg::cam_width{cfg.data_inv}};

   // Masked step flips the mask bits of the stored word
   assign cmp_data = wr_data ^
                     (bist_mask & {cam_bist_pkg::cam_width{cfg.cd_mask_en & step}});

   assign cam_wr.wr_en = (phase == cam_bist_pkg::phase_write);
   assign cam_wr.addr  = addr;
   assign cam_wr.data  = wr_data;

   // Key mux, BIST data only while comparing
   assign cam_cmp.valid = in_compare;
   assign cam_cmp.key   = in_compare ? cmp_data : func_key;

   // Rotation alone keeps the reset pattern one-hot
   a_mask_onehot : assert property (
      @(posedge bist_clk) disable iff (!rst_b) !scan_loaded |-> $onehot(bist_mask)
   );

endmodule

`default_nettype wire

// ==== rtl/cam_bist_checker.sv ====
// Match checker for the BIST engine.
// Expected result is derived from the issued key alone, so it holds for any
// mask pattern. Only the first failing entry is kept; start clears it.
// Assumes the CAM returns its match exactly one cycle after a compare.
`timescale 1ns/1ps
`default_nettype none

module cam_bist_checker (
   input  wire logic                                   bist_clk,
   input  wire logic                                   rst_b,
   input  wire logic                                   start,
   input  wire cam_bist_pkg::bist_cfg_t                cfg,
   input  wire logic [cam_bist_pkg::addr_width-1:0]    addr,
   input  wire cam_bist_pkg::cam_cmp_t                 cam_cmp,
   input  wire cam_bist_pkg::cam_match_t               cam_match,
   output logic                                        status_fail,
   output logic [cam_bist_pkg::addr_width-1:0]         status_fail_addr
);

   logic                                exp_hit_c;
   logic [cam_bist_pkg::addr_width-1:0] exp_addr_c;
   logic                                exp_vld;
   logic                                exp_hit;
   logic [cam_bist_pkg::addr_width-1:0] exp_addr;
   logic [cam_bist_pkg::addr_width-1:0] issue_addr;
   logic                                mismatch;

   // ------------------------------------------------------------------------
   // Expected result from the key
   // ------------------------------------------------------------------------
   // Hit only if the background field is intact
   assign exp_hit_c = (cam_cmp.key[cam_bist_pkg::cam_width-1:cam_bist_pkg::addr_width] ==
                       (cam_bist_pkg::bist_background ^
                        {cam_bist_pkg::bg_width{cfg.data_inv}}));

   // Address field of the key names the entry that should hit
   assign exp_addr_c = cam_cmp.key[cam_bist_pkg::addr_width-1:0] ^
                       {cam_bist_pkg::addr_width{cfg.data_inv}};

   // Align with the registered CAM result
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         exp_vld <= 1'b0;
      end else begin
         exp_vld <= cam_cmp.valid;
      end
   end

   always_ff @(posedge bist_clk) begin
      if (cam_cmp.valid) begin
         exp_hit    <= exp_hit_c;
         exp_addr   <= exp_addr_c;
         issue_addr <= addr;
      end
   end

   // ------------------------------------------------------------------------
   // Compare and first fail capture
   // ------------------------------------------------------------------------
   // Hit address is a don't care on an expected miss
   assign mismatch = exp_vld &&
                     ((cam_match.hit != exp_hit) ||
                      (exp_hit && (cam_match.addr != exp_addr)));

   always_ff @(posedge bist_clk) begin
      if (!rst_b || start) begin
         status_fail      <= 1'b0;
         status_fail_addr <= '0;
      end else if (mismatch && !status_fail) begin
         status_fail      <= 1'b1;
         status_fail_addr <= issue_addr;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cam_bist_top.sv ====
// Top level of the CAM BIST engine; the CAM array itself sits outside.
// cfg must be held stable for a whole run. A run takes 50 cycles from the
// start cycle to the done pulse. cam_match must follow cam_cmp.valid by one
// cycle. Outside a run the functional key goes straight to the CAM.
`timescale 1ns/1ps
`default_nettype none

module cam_bist_top (
   input  wire logic                                   bist_clk,
   input  wire logic                                   rst_b,
   input  wire logic                                   start,
   input  wire cam_bist_pkg::bist_cfg_t                cfg,
   input  wire logic                                   fscan_mode,
   input  wire logic [cam_bist_pkg::cam_width-1:0]     func_key,
   input  wire cam_bist_pkg::cam_match_t               cam_match,
   output cam_bist_pkg::cam_wr_t                       cam_wr,
   output cam_bist_pkg::cam_cmp_t                      cam_cmp,
   output cam_bist_pkg::bist_status_t                  status
);

   cam_bist_pkg::bist_phase_t           phase;
   logic                                cnt_en;
   logic                                cnt_clr;
   logic                                cnt_wrap;
   logic [cam_bist_pkg::addr_width-1:0] addr;
   logic                                step;
   logic                                busy;
   logic                                done;
   logic                                fail;
   logic [cam_bist_pkg::addr_width-1:0] fail_addr;

   // ------------------------------------------------------------------------
   // Sequencing
   // ------------------------------------------------------------------------
   cam_bist_ctrl ctrl_inst (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .start       (start),
      .cnt_wrap    (cnt_wrap),
      .phase       (phase),
      .cnt_en      (cnt_en),
      .cnt_clr     (cnt_clr),
      .status_busy (busy),
      .status_done (done)
   );

   cam_bist_addr_cnt addr_cnt_inst (
      .bist_clk (bist_clk),
      .rst_b    (rst_b),
      .cnt_en   (cnt_en),
      .cnt_clr  (cnt_clr),
      .phase    (phase),
      .addr     (addr),
      .step     (step),
      .cnt_wrap (cnt_wrap)
   );

   // ------------------------------------------------------------------------
   // CAM stimulus and response check
   // ------------------------------------------------------------------------
   cam_bist_inhandler inhandler_inst (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .phase      (phase),
      .addr       (addr),
      .step       (step),
      .cfg        (cfg),
      .fscan_mode (fscan_mode),
      .func_key   (func_key),
      .cam_wr     (cam_wr),
      .cam_cmp    (cam_cmp)
   );

   cam_bist_checker checker_inst (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .start            (start),
      .cfg              (cfg),
      .addr             (addr),
      .cam_cmp          (cam_cmp),
      .cam_match        (cam_match),
      .status_fail      (fail),
      .status_fail_addr (fail_addr)
   );

   // Status word
   assign status.busy      = busy;
   assign status.done      = done;
   assign status.fail      = fail;
   assign status.fail_addr = fail_addr;

endmodule

`default_nettype wire

// ==== tests/cam_model.sv ====
// Behavioral 16-entry binary CAM used as the BIST target.
// The match result is registered, so it follows a compare by one cycle.
// When several entries hold the key, the lowest index wins.
// One stuck bit can be injected; it is forced on every write to its entry.
`timescale 1ns/1ps
`default_nettype none

module cam_model (
   input  wire logic                                           bist_clk,
   input  wire logic                                           rst_b,
   input  wire cam_bist_pkg::cam_wr_t                          cam_wr,
   input  wire cam_bist_pkg::cam_cmp_t                         cam_cmp,
   input  wire logic                                           fault_en,
   input  wire logic [cam_bist_pkg::addr_width-1:0]            fault_entry,
   input  wire logic [$clog2(cam_bist_pkg::cam_width)-1:0]     fault_bit,
   input  wire logic                                           fault_val,
   output cam_bist_pkg::cam_match_t                            cam_match
);

   logic [cam_bist_pkg::cam_width-1:0]  mem [cam_bist_pkg::cam_entries];
   logic [cam_bist_pkg::cam_width-1:0]  wr_word;
   logic                                hit_c;
   logic [cam_bist_pkg::addr_width-1:0] hit_addr_c;

   // ------------------------------------------------------------------------
   // Write port with the stuck cell
   // ------------------------------------------------------------------------
   always_comb begin
      wr_word = cam_wr.data;
      // Faulty cell ignores the written value
      if (fault_en && (cam_wr.addr == fault_entry)) begin
         wr_word[fault_bit] = fault_val;
      end
   end

   always_ff @(posedge bist_clk) begin
      if (cam_wr.wr_en) begin
         mem[cam_wr.addr] <= wr_word;
      end
   end

   // ------------------------------------------------------------------------
   // Search
   // ------------------------------------------------------------------------
   // Scan from the top so the lowest matching entry is kept
   always_comb begin
      hit_c      = 1'b0;
      hit_addr_c = '0;
      for (int j = cam_bist_pkg::cam_entries - 1; j >= 0; j--) begin
         if (mem[j] == cam_cmp.key) begin
            hit_c      = 1'b1;
            hit_addr_c = cam_bist_pkg::addr_width'(j);
         end
      end
   end

   // Result register, cleared on cycles without a compare
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         cam_match <= '0;
      end else if (cam_cmp.valid) begin
         cam_match.hit  <= hit_c;
         cam_match.addr <= hit_addr_c;
      end else begin
         cam_match <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_cam_bist.sv ====
// Table-driven testbench for the CAM BIST engine with a behavioral CAM.
// Inputs change on the falling edge; outputs are sampled there too.
// Expected fail results come from the row or, for data-dependent faults,
// from a reference walk of the write and compare sequence.
// Rows share the mask state, so a scan load carries over to later rows.
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bist;

   // One stimulus row
   typedef struct packed {
      logic        data_inv;
      logic        cd_mask_en;
      logic        fault_en;
      logic [3:0]  fault_entry;
      logic        fault_rnd;
      logic [3:0]  fault_bit;
      logic        scan_en;
      logic [15:0] scan_val;
      logic        restart;
      logic        use_model;
      logic        exp_fail;
      logic [3:0]  exp_addr;
   } test_row_t;

   localparam int num_rows    = 9;
   localparam int run_cycles  = 50;
   localparam int cycle_limit = 60 * num_rows + 100;

   logic                       bist_clk;
   logic                       rst_b;
   logic                       start;
   logic                       fscan_mode;
   logic [15:0]                func_key;
   cam_bist_pkg::bist_cfg_t    cfg;
   cam_bist_pkg::cam_wr_t      cam_wr;
   cam_bist_pkg::cam_cmp_t     cam_cmp;
   cam_bist_pkg::cam_match_t   cam_match;
   cam_bist_pkg::bist_status_t status;
   logic                       fault_en;
   logic [3:0]                 fault_entry;
   logic [3:0]                 fault_bit;
   logic                       fault_val;

   test_row_t   rows [num_rows];
   integer      seed;
   int          cycle_count = 0;
   int          test_errors;
   int          error_count;
   int          failed_tests;
   logic [15:0] mask_start;

   cam_bist_top cam_bist_top_inst (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .start      (start),
      .cfg        (cfg),
      .fscan_mode (fscan_mode),
      .func_key   (func_key),
      .cam_match  (cam_match),
      .cam_wr     (cam_wr),
      .cam_cmp    (cam_cmp),
      .status     (status)
   );

   cam_model cam_model_inst (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .cam_wr      (cam_wr),
      .cam_cmp     (cam_cmp),
      .fault_en    (fault_en),
      .fault_entry (fault_entry),
      .fault_bit   (fault_bit),
      .fault_val   (fault_val),
      .cam_match   (cam_match)
   );

   initial bist_clk = 1'b0;
   always #5 bist_clk = ~bist_clk;

   // Watchdog over the whole run
   always @(posedge bist_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Run stopped after the cycle limit of %0d", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Reference rules
   // ------------------------------------------------------------------------
   // Background over the entry address with the whole word inverted on request
   function automatic logic [15:0] expected_write_word(input logic inv, input logic [3:0] e);
      return {cam_bist_pkg::bist_background, e} ^ {16{inv}};
   endfunction

   // Walks all compares against a faulty array and returns {fail, first fail entry}
   function automatic logic [4:0] predict_first_fail(
      input logic inv, input logic mask_en, input logic [15:0] mask0,
      input logic f_en, input logic [3:0] f_entry, input logic [3:0] f_bit,
      input logic f_val);
      logic [15:0] mem [16];
      logic [15:0] mask;
      logic [15:0] key;
      logic        hit;
      logic [3:0]  hit_addr;
      logic        exp_hit;
      logic [3:0]  exp_addr;
      for (int i = 0; i < 16; i++) begin
         mem[i] = expected_write_word(inv, 4'(i));
         if (f_en && (f_entry == 4'(i))) begin
            mem[i][f_bit] = f_val;
         end
      end
      mask = mask0;
      for (int k = 0; k < 16; k++) begin
         for (int s = 0; s < 2; s++) begin
            key = expected_write_word(inv, 4'(k));
            if ((s == 1) && mask_en) begin
               key = key ^ mask;
            end
            // Lowest matching entry wins
            hit      = 1'b0;
            hit_addr = 4'd0;
            for (int j = 15; j >= 0; j--) begin
               if (mem[j] == key) begin
                  hit      = 1'b1;
                  hit_addr = 4'(j);
               end
            end
            exp_hit  = (key[15:4] == (cam_bist_pkg::bist_background ^ {12{inv}}));
            exp_addr = key[3:0] ^ {4{inv}};
            if ((hit != exp_hit) || (exp_hit && (hit_addr != exp_addr))) begin
               return {1'b1, 4'(k)};
            end
            if (s == 1) begin
               mask = {mask[14:0], mask[15]};
            end
         end
      end
      return 5'd0;
   endfunction

   // ------------------------------------------------------------------------
   // Stimulus tasks
   // ------------------------------------------------------------------------
   // Idle engine passes the functional key straight through
   task automatic check_func_key_path();
      logic [15:0] k;
      k = 16'($random(seed));
      @(negedge bist_clk);
      func_key = k;
      #2;
      if (cam_cmp.key !== k) begin
         $display("[ERROR] cam_cmp.key: got 0x%0h, expected 0x%0h", cam_cmp.key, k);
         test_errors++;
      end
      if (cam_cmp.valid !== 1'b0) begin
         $display("[ERROR] cam_cmp.valid: got 0x%0h, expected 0x0", cam_cmp.valid);
         test_errors++;
      end
   endtask

   task automatic apply_row(input int idx);
      test_row_t   r;
      logic [31:0] rnd;
      logic [3:0]  bit_sel;
      logic [15:0] gw;
      logic [4:0]  pred;
      logic        exp_fail;
      logic [3:0]  exp_addr;
      int          cycles;
      int          writes;
      logic        done_seen;
      r           = rows[idx];
      test_errors = 0;
      bit_sel     = r.fault_bit;
      // Random fault lands somewhere in the background field
      if (r.fault_rnd) begin
         rnd     = $random(seed);
         bit_sel = 4'(cam_bist_pkg::addr_width + rnd % cam_bist_pkg::bg_width);
      end
      gw = expected_write_word(r.data_inv, r.fault_entry);
      if (r.scan_en) begin
         check_func_key_path();
         // One cycle of scan load into the mask
         @(negedge bist_clk);
         fscan_mode = 1'b1;
         func_key   = r.scan_val;
         @(negedge bist_clk);
         fscan_mode = 1'b0;
         mask_start = r.scan_val;
      end
      @(negedge bist_clk);
      cfg.data_inv   = r.data_inv;
      cfg.cd_mask_en = r.cd_mask_en;
      fault_en       = r.fault_en;
      fault_entry    = r.fault_entry;
      fault_bit      = bit_sel;
      // Stuck value is the opposite of the good bit
      fault_val      = ~gw[bit_sel];
      exp_fail       = r.exp_fail;
      exp_addr       = r.exp_addr;
      if (r.use_model) begin
         pred     = predict_first_fail(r.data_inv, r.cd_mask_en, mask_start, r.fault_en,
                                       r.fault_entry, bit_sel, ~gw[bit_sel]);
         exp_fail = pred[4];
         exp_addr = pred[3:0];
      end
      start     = 1'b1;
      cycles    = 0;
      writes    = 0;
      done_seen = 1'b0;
      while (!done_seen && (cycles < run_cycles + 10)) begin
         @(posedge bist_clk);
         cycles++;
         @(negedge bist_clk);
         start = 1'b0;
         // Second start in the middle of the write phase
         if (r.restart && (cycles == 10)) begin
            start = 1'b1;
         end
         if (status.done) begin
            done_seen = 1'b1;
         end else begin
            if (status.busy !== 1'b1) begin
               $display("[ERROR] status.busy: got 0x%0h, expected 0x1", status.busy);
               test_errors++;
            end
            if (cam_wr.wr_en) begin
               if (cam_wr.addr !== 4'(writes)) begin
                  $display("[ERROR] cam_wr.addr: got 0x%0h, expected 0x%0h",
                           cam_wr.addr, 4'(writes));
                  test_errors++;
               end
               if (cam_wr.data !== expected_write_word(r.data_inv, 4'(writes))) begin
                  $display("[ERROR] cam_wr.data: got 0x%0h, expected 0x%0h", cam_wr.data,
                           expected_write_word(r.data_inv, 4'(writes)));
                  test_errors++;
               end
               writes++;
            end
         end
      end
      if (!done_seen) begin
         $display("Test %0d: the done pulse never arrived", idx);
         test_errors++;
      end else begin
         if (cycles != run_cycles) begin
            $display("[ERROR] done latency: got 0x%0h, expected 0x%0h", cycles, run_cycles);
            test_errors++;
         end
         if (status.busy !== 1'b0) begin
            $display("[ERROR] status.busy at done: got 0x%0h, expected 0x0", status.busy);
            test_errors++;
         end
         if (writes != 16) begin
            $display("[ERROR] write count: got 0x%0h, expected 0x10", writes);
            test_errors++;
         end
         if (status.fail !== exp_fail) begin
            $display("[ERROR] status.fail: got 0x%0h, expected 0x%0h", status.fail, exp_fail);
            test_errors++;
         end
         if (exp_fail && (status.fail_addr !== exp_addr)) begin
            $display("[ERROR] status.fail_addr: got 0x%0h, expected 0x%0h",
                     status.fail_addr, exp_addr);
            test_errors++;
         end
         // Done lasts a single cycle
         @(negedge bist_clk);
         if (status.done !== 1'b0) begin
            $display("[ERROR] status.done after pulse: got 0x%0h, expected 0x0", status.done);
            test_errors++;
         end
      end
      if (test_errors == 0) begin
         $display("Test %0d (inv %0d, mask %0d, fault %0d at %0d.%0d): ok",
                  idx, r.data_inv, r.cd_mask_en, r.fault_en, r.fault_entry, bit_sel);
      end else begin
         $display("Test %0d (inv %0d, mask %0d, fault %0d at %0d.%0d): %0d errors",
                  idx, r.data_inv, r.cd_mask_en, r.fault_en, r.fault_entry, bit_sel,
                  test_errors);
         failed_tests++;
      end
      error_count += test_errors;
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      seed         = 32'h9404_4d35;
      rst_b        = 1'b0;
      start        = 1'b0;
      fscan_mode   = 1'b0;
      func_key     = 16'h0000;
      cfg          = '0;
      fault_en     = 1'b0;
      fault_entry  = 4'd0;
      fault_bit    = 4'd0;
      fault_val    = 1'b0;
      mask_start   = 16'h0001;
      error_count  = 0;
      failed_tests = 0;
      // inv, mask_en, fault_en, entry, rnd bit, bit, scan_en, scan value,
      // restart, use model, exp fail, exp fail addr
      rows[0] = '{1'b0, 1'b1, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b0, 4'd0};
      rows[1] = '{1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b0, 4'd0};
      rows[2] = '{1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b0, 4'd0};
      // Background faults make the plain compare of the entry miss first
      rows[3] = '{1'b0, 1'b1, 1'b1, 4'd5, 1'b1, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b1, 4'd5};
      rows[4] = '{1'b1, 1'b1, 1'b1, 4'd9, 1'b1, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b1, 4'd9};
      // Address bit fault aliases entry 2 onto entry 3
      rows[5] = '{1'b0, 1'b1, 1'b1, 4'd2, 1'b0, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 4'd0};
      rows[6] = '{1'b0, 1'b1, 1'b0, 4'd0, 1'b0, 4'd0, 1'b1, 16'h0100, 1'b0, 1'b0, 1'b0, 4'd0};
      rows[7] = '{1'b1, 1'b1, 1'b0, 4'd0, 1'b0, 4'd0, 1'b0, 16'h0000, 1'b1, 1'b0, 1'b0, 4'd0};
      rows[8] = '{1'b0, 1'b1, 1'b1, 4'd6, 1'b1, 4'd0, 1'b0, 16'h0000, 1'b0, 1'b1, 1'b0, 4'd0};
      repeat (2) @(posedge bist_clk);
      @(negedge bist_clk);
      // Reset values before release
      if (status !== '0) begin
         $display("[ERROR] status after reset: got 0x%0h, expected 0x00", status);
         error_count++;
      end
      if (cam_wr.wr_en !== 1'b0) begin
         $display("[ERROR] cam_wr.wr_en after reset: got 0x%0h, expected 0x0", cam_wr.wr_en);
         error_count++;
      end
      if (cam_cmp.valid !== 1'b0) begin
         $display("[ERROR] cam_cmp.valid after reset: got 0x%0h, expected 0x0",
                  cam_cmp.valid);
         error_count++;
      end
      rst_b = 1'b1;
      for (int idx = 0; idx < num_rows; idx++) begin
         apply_row(idx);
      end
      $display("Summary: %0d tests, %0d failed, %0d errors", num_rows, failed_tests,
               error_count);
      if (error_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/cam_bist_pkg.sv
rtl/cam_bist_ctrl.sv
rtl/cam_bist_addr_cnt.sv
rtl/cam_bist_inhandler.sv
rtl/cam_bist_checker.sv
rtl/cam_bist_top.sv
tests/cam_model.sv
tests/tb_cam_bist.sv

// ==== run.sh ====
#!/bin/sh
# Build the CAM BIST testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_cam_bist -o tb_cam_bist
./obj_dir/tb_cam_bist > sim.log 2>&1 || true
cat sim.log
if grep -qx "Simulation passed" sim.log; then
   echo "run.sh: PASS"
   exit 0
fi
echo "run.sh: FAIL"
exit 1
